/* common/axi_lite_pkg.sv */
// Shared widths, limits, response codes and channel payload structs for the AXI4-Lite master
package axi_lite_pkg;

   ////////////////////////////////////////
   // Bus geometry
   ////////////////////////////////////////

   // Byte address on AW and AR
   localparam int addr_width = 32;

   // Single data lane
   localparam int data_width = 32;

   // One strobe per data byte
   localparam int strb_width = data_width / 8;

   // Responses that may be pending on each path
   localparam int max_outstanding = 4;

   // Wide enough to hold max_outstanding itself
   typedef logic [2:0] count_t;

   ////////////////////////////////////////
   // Response codes
   ////////////////////////////////////////

   // BRESP / RRESP encoding as on the bus
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } resp_t;

   ////////////////////////////////////////
   // Channel payloads
   ////////////////////////////////////////

   // AW and AR beat, address only in AXI4-Lite
   typedef struct packed {
      logic [addr_width-1:0] addr;
   } addr_beat_t;

   // W beat
   typedef struct packed {
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } wdata_beat_t;

   // B beat
   typedef struct packed {
      resp_t resp;
   } wresp_beat_t;

   // R beat
   typedef struct packed {
      logic [data_width-1:0] data;
      resp_t                 resp;
   } rdata_beat_t;

   // User write command
   // Split later into one AW and one W beat
   typedef struct packed {
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } wr_cmd_t;

endpackage

/* design/channel_buffer.sv */
// Two-entry valid/ready buffer with registered outputs, placed on each AXI4-Lite channel
`timescale 1ns/1ps

module channel_buffer #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,

   // Upstream side
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,

   // Downstream side
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Spill entry holds a beat that arrived while the output stalled
   logic     spill_valid;
   payload_t spill_data;

   logic     in_fire;
   logic     out_free;

   ////////////////////////////////////////
   // Handshake terms
   ////////////////////////////////////////

   assign in_fire = in_valid && in_ready;

   // Primary entry empty or draining this edge
   assign out_free = !out_valid || out_ready;

   // Straight from a flop, so no path from out_ready
   assign in_ready = !spill_valid;

   ////////////////////////////////////////
   // Occupancy
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_valid   <= 1'b0;
         spill_valid <= 1'b0;
      end
      else if (out_free)
      begin
         // Spill drains first, else the new beat goes straight through
         out_valid   <= spill_valid || in_fire;
         spill_valid <= 1'b0;
      end
      else if (in_fire)
      begin
         // Output stalled, park the beat
         spill_valid <= 1'b1;
      end
   end

   // Payload path
   always_ff @(posedge clk)
   begin
      if (out_free)
      begin
         if (spill_valid)
            out_data <= spill_data;
         else if (in_fire)
            out_data <= in_data;
      end
      else if (in_fire)
      begin
         spill_data <= in_data;
      end
   end

endmodule

/* write_path/write_issuer.sv */
// Write command front end that feeds the AW and W buffers and returns B status to the user
`timescale 1ns/1ps

module write_issuer (
   input  logic                      clk,
   input  logic                      reset,

   // User write command
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  axi_lite_pkg::wr_cmd_t     cmd,

   // Into the aw buffer
   output logic                      aw_valid,
   input  logic                      aw_ready,
   output axi_lite_pkg::addr_beat_t  aw_data,

   // Into the w buffer
   output logic                      w_valid,
   input  logic                      w_ready,
   output axi_lite_pkg::wdata_beat_t w_data,

   // Out of the b buffer
   input  logic                      b_valid,
   output logic                      b_ready,

   // User write response handshake
   output logic                      rsp_valid,
   input  logic                      rsp_ready
);

   axi_lite_pkg::count_t count;
   logic                 below_limit;
   logic                 accept;
   logic                 retire;

   ////////////////////////////////////////
   // Command acceptance
   ////////////////////////////////////////

   // Room for one more pending response
   assign below_limit = count < axi_lite_pkg::count_t'(axi_lite_pkg::max_outstanding);

   // Both beats must fit in the same cycle
   assign cmd_ready = aw_ready && w_ready && below_limit;
   assign accept    = cmd_valid && cmd_ready;

   // Each valid is gated by the other channel's ready only
   // so both beats always transfer together
   assign aw_valid = cmd_valid && w_ready && below_limit;
   assign w_valid  = cmd_valid && aw_ready && below_limit;

   // Split the command into its two beats
   assign aw_data.addr = cmd.addr;
   assign w_data.data  = cmd.data;
   assign w_data.strb  = cmd.strb;

   ////////////////////////////////////////
   // Response return
   ////////////////////////////////////////

   // B payload goes from the buffer to the user port directly
   assign rsp_valid = b_valid;
   assign b_ready   = rsp_ready;

   // Write retires once its status reaches the user
   assign retire = rsp_valid && rsp_ready;

   // Outstanding write count
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else if (accept && !retire)
      begin
         count <= count + axi_lite_pkg::count_t'(1);
      end
      else if (retire && !accept)
      begin
         count <= count - axi_lite_pkg::count_t'(1);
      end
   end

endmodule

/* read_path/read_issuer.sv */
// Read command front end that feeds the AR buffer and returns R data to the user
`timescale 1ns/1ps

module read_issuer (
   input  logic                     clk,
   input  logic                     reset,

   // User read command
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   input  axi_lite_pkg::addr_beat_t cmd,

   // Into the ar buffer
   output logic                     ar_valid,
   input  logic                     ar_ready,
   output axi_lite_pkg::addr_beat_t ar_data,

   // Out of the r buffer
   input  logic                     r_valid,
   output logic                     r_ready,

   // User read response handshake
   output logic                     rsp_valid,
   input  logic                     rsp_ready
);

   axi_lite_pkg::count_t count;
   logic                 below_limit;
   logic                 accept;
   logic                 retire;

   // Room for one more pending read
   assign below_limit = count < axi_lite_pkg::count_t'(axi_lite_pkg::max_outstanding);

   // Valid never looks at ar_ready
   assign ar_valid  = cmd_valid && below_limit;
   assign cmd_ready = ar_ready && below_limit;
   assign accept    = cmd_valid && cmd_ready;
   assign ar_data   = cmd;

   // R payload bypasses this block
   assign rsp_valid = r_valid;
   assign r_ready   = rsp_ready;
   assign retire    = rsp_valid && rsp_ready;

   // Outstanding read count
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else if (accept && !retire)
      begin
         count <= count + axi_lite_pkg::count_t'(1);
      end
      else if (retire && !accept)
      begin
         count <= count - axi_lite_pkg::count_t'(1);
      end
   end

endmodule

/* design/axi_lite_master_top.sv */
// Command-driven AXI4-Lite master, user command and response ports on one side, AXI on the other
`timescale 1ns/1ps

module axi_lite_master_top (
   input  logic                      clk,
   input  logic                      reset,

   // User write command and status
   input  logic                      wr_cmd_valid,
   output logic                      wr_cmd_ready,
   input  axi_lite_pkg::wr_cmd_t     wr_cmd,
   output logic                      wr_rsp_valid,
   input  logic                      wr_rsp_ready,
   output axi_lite_pkg::wresp_beat_t wr_rsp,

   // User read command and data
   input  logic                      rd_cmd_valid,
   output logic                      rd_cmd_ready,
   input  axi_lite_pkg::addr_beat_t  rd_cmd,
   output logic                      rd_rsp_valid,
   input  logic                      rd_rsp_ready,
   output axi_lite_pkg::rdata_beat_t rd_rsp,

   // AXI4-Lite write channels
   output logic                      awvalid,
   input  logic                      awready,
   output axi_lite_pkg::addr_beat_t  aw,
   output logic                      wvalid,
   input  logic                      wready,
   output axi_lite_pkg::wdata_beat_t w,
   input  logic                      bvalid,
   output logic                      bready,
   input  axi_lite_pkg::wresp_beat_t b,

   // AXI4-Lite read channels
   output logic                      arvalid,
   input  logic                      arready,
   output axi_lite_pkg::addr_beat_t  ar,
   input  logic                      rvalid,
   output logic                      rready,
   input  axi_lite_pkg::rdata_beat_t r
);

   ////////////////////////////////////////
   // Issuer to buffer wiring
   ////////////////////////////////////////

   logic                      aw_in_valid;
   logic                      aw_in_ready;
   axi_lite_pkg::addr_beat_t  aw_in_data;
   logic                      w_in_valid;
   logic                      w_in_ready;
   axi_lite_pkg::wdata_beat_t w_in_data;
   logic                      b_out_valid;
   logic                      b_out_ready;
   logic                      ar_in_valid;
   logic                      ar_in_ready;
   axi_lite_pkg::addr_beat_t  ar_in_data;
   logic                      r_out_valid;
   logic                      r_out_ready;

   // Write path
   write_issuer u_write_issuer (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (wr_cmd_valid),
      .cmd_ready (wr_cmd_ready),
      .cmd       (wr_cmd),
      .aw_valid  (aw_in_valid),
      .aw_ready  (aw_in_ready),
      .aw_data   (aw_in_data),
      .w_valid   (w_in_valid),
      .w_ready   (w_in_ready),
      .w_data    (w_in_data),
      .b_valid   (b_out_valid),
      .b_ready   (b_out_ready),
      .rsp_valid (wr_rsp_valid),
      .rsp_ready (wr_rsp_ready)
   );

   // Read path
   read_issuer u_read_issuer (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (rd_cmd_valid),
      .cmd_ready (rd_cmd_ready),
      .cmd       (rd_cmd),
      .ar_valid  (ar_in_valid),
      .ar_ready  (ar_in_ready),
      .ar_data   (ar_in_data),
      .r_valid   (r_out_valid),
      .r_ready   (r_out_ready),
      .rsp_valid (rd_rsp_valid),
      .rsp_ready (rd_rsp_ready)
   );

   ////////////////////////////////////////
   // Channel buffers
   ////////////////////////////////////////

   // Outgoing channels
   channel_buffer #(.payload_t(axi_lite_pkg::addr_beat_t)) aw_buffer (
      .clk (clk), .reset (reset),
      .in_valid (aw_in_valid), .in_ready (aw_in_ready), .in_data (aw_in_data),
      .out_valid (awvalid), .out_ready (awready), .out_data (aw)
   );

   channel_buffer #(.payload_t(axi_lite_pkg::wdata_beat_t)) w_buffer (
      .clk (clk), .reset (reset),
      .in_valid (w_in_valid), .in_ready (w_in_ready), .in_data (w_in_data),
      .out_valid (wvalid), .out_ready (wready), .out_data (w)
   );

   channel_buffer #(.payload_t(axi_lite_pkg::addr_beat_t)) ar_buffer (
      .clk (clk), .reset (reset),
      .in_valid (ar_in_valid), .in_ready (ar_in_ready), .in_data (ar_in_data),
      .out_valid (arvalid), .out_ready (arready), .out_data (ar)
   );

   // Incoming channels, payload lands on the user response ports
   channel_buffer #(.payload_t(axi_lite_pkg::wresp_beat_t)) b_buffer (
      .clk (clk), .reset (reset),
      .in_valid (bvalid), .in_ready (bready), .in_data (b),
      .out_valid (b_out_valid), .out_ready (b_out_ready), .out_data (wr_rsp)
   );

   channel_buffer #(.payload_t(axi_lite_pkg::rdata_beat_t)) r_buffer (
      .clk (clk), .reset (reset),
      .in_valid (rvalid), .in_ready (rready), .in_data (r),
      .out_valid (r_out_valid), .out_ready (r_out_ready), .out_data (rd_rsp)
   );

endmodule

/* testbench/axi_lite_master_sva.sv */
// AXI4-Lite port protocol assertions bound into the master top level
`timescale 1ns/1ps

module axi_lite_master_sva (
   input logic                      clk,
   input logic                      reset,
   input logic                      awvalid,
   input logic                      awready,
   input axi_lite_pkg::addr_beat_t  aw,
   input logic                      wvalid,
   input logic                      wready,
   input axi_lite_pkg::wdata_beat_t w,
   input logic                      arvalid,
   input logic                      arready,
   input axi_lite_pkg::addr_beat_t  ar,
   input logic                      bready,
   input logic                      rready
);

   // Failed assertion tally read by the testbench
   int unsigned fail_count = 0;

   // Valid and payload hold until the beat transfers
   aw_stable: assert property (@(posedge clk) disable iff (reset)
      awvalid && !awready |=> awvalid && $stable(aw))
   else
   begin
      fail_count++;
      $error("AW changed before awready");
   end

   w_stable: assert property (@(posedge clk) disable iff (reset)
      wvalid && !wready |=> wvalid && $stable(w))
   else
   begin
      fail_count++;
      $error("W changed before wready");
   end

   ar_stable: assert property (@(posedge clk) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(ar))
   else
   begin
      fail_count++;
      $error("AR changed before arready");
   end

   // Outgoing valids cleared by reset
   reset_valids_low: assert property (@(posedge clk)
      reset |=> !awvalid && !wvalid && !arvalid)
   else
   begin
      fail_count++;
      $error("Valid high after a reset edge");
   end

   // Both response buffers empty once reset drops
   ready_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> bready && rready)
   else
   begin
      fail_count++;
      $error("bready or rready low after reset");
   end

endmodule

bind axi_lite_master_top axi_lite_master_sva protocol_checks (
   .clk (clk), .reset (reset),
   .awvalid (awvalid), .awready (awready), .aw (aw),
   .wvalid (wvalid), .wready (wready), .w (w),
   .arvalid (arvalid), .arready (arready), .ar (ar),
   .bready (bready), .rready (rready)
);

/* testbench/tb_axi_lite_master.sv */
// Self-checking testbench for the AXI4-Lite master, which also plays a random-latency slave
`timescale 1ns/1ps

module tb_axi_lite_master;

   localparam int num_cmds       = 300;
   localparam int timeout_cycles = num_cmds * 25 + 500;
   localparam int max_delay      = 5;

   logic clk;
   logic reset;

   // DUT user side
   logic                      wr_cmd_valid, wr_cmd_ready, wr_rsp_valid, wr_rsp_ready;
   logic                      rd_cmd_valid, rd_cmd_ready, rd_rsp_valid, rd_rsp_ready;
   axi_lite_pkg::wr_cmd_t     wr_cmd;
   axi_lite_pkg::addr_beat_t  rd_cmd;
   axi_lite_pkg::wresp_beat_t wr_rsp;
   axi_lite_pkg::rdata_beat_t rd_rsp;

   // DUT AXI side
   logic                      awvalid, awready, wvalid, wready, bvalid, bready;
   logic                      arvalid, arready, rvalid, rready;
   axi_lite_pkg::addr_beat_t  aw, ar;
   axi_lite_pkg::wdata_beat_t w;
   axi_lite_pkg::wresp_beat_t b;
   axi_lite_pkg::rdata_beat_t r;

   // Slave memory indexed by address bits 5:2
   logic [axi_lite_pkg::data_width-1:0] mem [16];

   // Scoreboard queues filled from the user commands
   axi_lite_pkg::addr_beat_t  exp_aw[$];
   axi_lite_pkg::wdata_beat_t exp_w[$];
   axi_lite_pkg::resp_t       exp_wr_rsp[$];
   axi_lite_pkg::addr_beat_t  exp_ar[$];
   axi_lite_pkg::rdata_beat_t exp_rd_rsp[$];

   // Slave side beats waiting for pairing or for their response slot
   axi_lite_pkg::addr_beat_t  slv_aw[$];
   axi_lite_pkg::wdata_beat_t slv_w[$];
   axi_lite_pkg::wresp_beat_t b_pend[$];
   axi_lite_pkg::rdata_beat_t r_pend[$];

   axi_lite_pkg::addr_beat_t  pair_aw;
   axi_lite_pkg::wdata_beat_t pair_w;
   axi_lite_pkg::rdata_beat_t rd_beat;
   logic [axi_lite_pkg::addr_width-1:0] exp_addr;
   axi_lite_pkg::wdata_beat_t exp_wbeat;
   axi_lite_pkg::resp_t       exp_resp;

   // Handshakes seen at the last rising edge
   logic wr_cmd_fire, rd_cmd_fire, b_fire, r_fire;
   int   cycle, issued, done_count, wr_open, rd_open, b_wait, r_wait;

   axi_lite_master_top dut (.*);

   always #2 clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   // Bit 6 picks the error region and bits 5:2 the word
   function automatic logic [31:0] random_addr();
      return $urandom & 32'h0FFF_FFFC;
   endfunction

   ////////////////////////////////////////
   // Monitor and scoreboard
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      wr_cmd_fire = wr_cmd_valid && wr_cmd_ready;
      rd_cmd_fire = rd_cmd_valid && rd_cmd_ready;
      b_fire      = bvalid && bready;
      r_fire      = rvalid && rready;
      // Bound protocol checker
      assert (dut.protocol_checks.fail_count == 0)
         else stop_on_error("Protocol assertion failed on the AXI ports");
      if (!reset)
      begin
         cycle++;
         if (cycle >= timeout_cycles)
            stop_on_error($sformatf("Timeout with %0d of %0d responses", done_count, num_cmds));
         // Outstanding limit per path
         assert (wr_open <= axi_lite_pkg::max_outstanding && rd_open <= axi_lite_pkg::max_outstanding)
            else stop_on_error("More than four commands outstanding on one path");
         if (wr_open == axi_lite_pkg::max_outstanding)
            assert (!wr_cmd_ready) else stop_on_error("Write command ready at the outstanding limit");
         if (rd_open == axi_lite_pkg::max_outstanding)
            assert (!rd_cmd_ready) else stop_on_error("Read command ready at the outstanding limit");
         if (wr_cmd_fire)
         begin
            exp_aw.push_back(wr_cmd.addr);
            exp_w.push_back({wr_cmd.data, wr_cmd.strb});
            exp_wr_rsp.push_back(wr_cmd.addr[6] ? axi_lite_pkg::resp_slverr : axi_lite_pkg::resp_okay);
            wr_open++;
         end
         if (rd_cmd_fire)
         begin
            exp_ar.push_back(rd_cmd);
            rd_open++;
         end
         if (awvalid && awready)
         begin
            assert (exp_aw.size() > 0) else stop_on_error("AW beat with no write command");
            exp_addr = exp_aw.pop_front();
            assert (aw.addr == exp_addr)
               else stop_on_error($sformatf("FAILED aw.addr got %h expected %h", aw.addr, exp_addr));
            slv_aw.push_back(aw);
         end
         if (wvalid && wready)
         begin
            assert (exp_w.size() > 0) else stop_on_error("W beat with no write command");
            exp_wbeat = exp_w.pop_front();
            assert (w == exp_wbeat)
               else stop_on_error($sformatf("FAILED w got %h expected %h", w, exp_wbeat));
            slv_w.push_back(w);
         end
         // Slave pairs AW and W in order, then merges by strobe
         if (slv_aw.size() > 0 && slv_w.size() > 0)
         begin
            pair_aw = slv_aw.pop_front();
            pair_w  = slv_w.pop_front();
            if (!pair_aw.addr[6])
            begin
               for (int i = 0; i < axi_lite_pkg::strb_width; i++)
                  if (pair_w.strb[i])
                     mem[pair_aw.addr[5:2]][8*i +: 8] = pair_w.data[8*i +: 8];
            end
            b_pend.push_back(pair_aw.addr[6] ? axi_lite_pkg::resp_slverr : axi_lite_pkg::resp_okay);
         end
         if (arvalid && arready)
         begin
            assert (exp_ar.size() > 0) else stop_on_error("AR beat with no read command");
            exp_addr = exp_ar.pop_front();
            assert (ar.addr == exp_addr)
               else stop_on_error($sformatf("FAILED ar.addr got %h expected %h", ar.addr, exp_addr));
            // Error region reads back as zero
            rd_beat.data = ar.addr[6] ? '0 : mem[ar.addr[5:2]];
            rd_beat.resp = ar.addr[6] ? axi_lite_pkg::resp_slverr : axi_lite_pkg::resp_okay;
            r_pend.push_back(rd_beat);
            exp_rd_rsp.push_back(rd_beat);
         end
         if (wr_rsp_valid && wr_rsp_ready)
         begin
            assert (exp_wr_rsp.size() > 0) else stop_on_error("Write response with no write pending");
            exp_resp = exp_wr_rsp.pop_front();
            assert (wr_rsp.resp == exp_resp)
               else stop_on_error($sformatf("FAILED wr_rsp.resp got %h expected %h",
                                            wr_rsp.resp, exp_resp));
            wr_open--;
            done_count++;
         end
         if (rd_rsp_valid && rd_rsp_ready)
         begin
            assert (exp_rd_rsp.size() > 0) else stop_on_error("Read response with no read pending");
            rd_beat = exp_rd_rsp.pop_front();
            assert (rd_rsp == rd_beat)
               else stop_on_error($sformatf("FAILED rd_rsp got %h expected %h", rd_rsp, rd_beat));
            rd_open--;
            done_count++;
         end
      end
   end

   ////////////////////////////////////////
   // Falling edge stimulus
   ////////////////////////////////////////

   task automatic drive_commands();
      if (!wr_cmd_valid || wr_cmd_fire)
      begin
         wr_cmd_valid = 1'b0;
         if (issued < num_cmds && $urandom_range(0, 2) == 0)
         begin
            wr_cmd       = {random_addr(), 32'($urandom), 4'($urandom_range(0, 15))};
            wr_cmd_valid = 1'b1;
            issued++;
         end
      end
      if (!rd_cmd_valid || rd_cmd_fire)
      begin
         rd_cmd_valid = 1'b0;
         if (issued < num_cmds && $urandom_range(0, 2) == 0)
         begin
            rd_cmd.addr  = random_addr();
            rd_cmd_valid = 1'b1;
            issued++;
         end
      end
      // Long stretches of held-off readies fill the response buffers
      wr_rsp_ready = ((cycle / 50) % 4 == 3) ? 1'b0 : ($urandom_range(0, 3) != 0);
      rd_rsp_ready = ((cycle / 50) % 4 == 1) ? 1'b0 : ($urandom_range(0, 3) != 0);
   endtask

   task automatic drive_slave();
      awready = $urandom_range(0, 3) != 0;
      wready  = $urandom_range(0, 3) != 0;
      arready = $urandom_range(0, 3) != 0;
      // Delay drawn once a response reaches the head
      if (!bvalid || b_fire)
      begin
         bvalid = 1'b0;
         if (b_pend.size() > 0)
         begin
            if (b_wait < 0)
               b_wait = $urandom_range(0, max_delay);
            if (b_wait == 0)
            begin
               b      = b_pend.pop_front();
               bvalid = 1'b1;
            end
            b_wait--;
         end
      end
      if (!rvalid || r_fire)
      begin
         rvalid = 1'b0;
         if (r_pend.size() > 0)
         begin
            if (r_wait < 0)
               r_wait = $urandom_range(0, max_delay);
            if (r_wait == 0)
            begin
               r      = r_pend.pop_front();
               rvalid = 1'b1;
            end
            r_wait--;
         end
      end
   endtask

   initial
   begin
      void'($urandom(74533));
      clk = 1'b0;
      reset = 1'b1;
      wr_cmd_valid = 1'b0;
      wr_cmd = '0;
      rd_cmd_valid = 1'b0;
      rd_cmd = '0;
      wr_rsp_ready = 1'b0;
      rd_rsp_ready = 1'b0;
      {awready, wready, arready, bvalid, rvalid} = '0;
      b = '0;
      r = '0;
      {wr_cmd_fire, rd_cmd_fire, b_fire, r_fire} = '0;
      {cycle, issued, done_count, wr_open, rd_open} = '0;
      b_wait = -1;
      r_wait = -1;
      // Fill pattern built from the full word index
      for (int i = 0; i < 16; i++)
         mem[i] = {8{i[3:0]}};
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      assert (!awvalid && !wvalid && !arvalid && !wr_rsp_valid && !rd_rsp_valid)
         else stop_on_error("Valid output high right after reset");
      while (done_count < num_cmds)
      begin
         @(negedge clk);
         drive_commands();
         drive_slave();
      end
      assert (exp_aw.size() == 0 && exp_w.size() == 0 && exp_ar.size() == 0 && b_pend.size() == 0)
         else stop_on_error("Beats left over at the end of the run");
      assert (dut.protocol_checks.fail_count == 0)
         else stop_on_error("Protocol assertion failed on the AXI ports");
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* axi_lite_master_top.f */
common/axi_lite_pkg.sv
design/channel_buffer.sv
write_path/write_issuer.sv
read_path/read_issuer.sv
design/axi_lite_master_top.sv
testbench/axi_lite_master_sva.sv
testbench/tb_axi_lite_master.sv

/* Bender.yml */
package:
  name: axi_lite_master

dependencies: {}

sources:
  # Shared package first
  - common/axi_lite_pkg.sv
  # RTL
  - design/channel_buffer.sv
  - write_path/write_issuer.sv
  - read_path/read_issuer.sv
  - design/axi_lite_master_top.sv
  # Testbench
  - target: test
    files:
      - testbench/axi_lite_master_sva.sv
      - testbench/tb_axi_lite_master.sv
